/* project.f */
hdl/ifu_pkg.sv
hdl/ifu_minidec.sv
hdl/ifu_bpu.sv
hdl/ifu_pc_gen.sv
hdl/ifu_top.sv
verif/ifu_assertions.sv
verif/ifu_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = ifu_tb
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# The run fails on the fail message, or when the pass message never appears
run: build
	-./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
	  echo "Simulation reported failure"; exit 1; \
	elif ! grep -q "Verification passed" $(LOG); then \
	  echo "Simulation ended without a result"; exit 1; \
	else \
	  echo "Simulation OK"; \
	fi

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

/* verif/ifu_tb.sv */
// Table-driven fetch test; assumes pc_size of 32, 12-bit JALR offsets and a free-running clock
`timescale 1ns/1ps

module ifu_tb;

  // ============================================================
  // Constants and stimulus row layout
  // ============================================================

  localparam int                       pc_width   = 32;
  localparam logic [ifu_pkg::xlen-1:0] start_pc   = 32'h0000_1000;
  localparam int                       poll_limit = 10;

  // Instruction kinds used to build and to predict each row
  localparam logic [1:0] kind_other = 2'd0;
  localparam logic [1:0] kind_jal   = 2'd1;
  localparam logic [1:0] kind_bxx   = 2'd2;
  localparam logic [1:0] kind_jalr  = 2'd3;

  // addi x5, x0, 1 stands in for any non-branch instruction
  localparam logic [31:0] nop_instr = 32'h0010_0293;

  typedef struct packed {
    logic [1:0]  kind;
    logic [31:0] off;
    logic [4:0]  rs1;
    logic [31:0] instr;
    logic        instr_valid;
    logic        oitf_empty;
    logic        ir_valid;
    logic        ir_rd_wen;
    logic [4:0]  ir_rd_idx;
    logic        exp_taken;
    logic        exp_wait;
    int          hold;
  } stim_row_t;

  logic                            clk;
  logic                            reset;
  logic [ifu_pkg::xlen-1:0]        instr;
  logic                            instr_valid;
  logic                            oitf_empty;
  logic                            ir_valid;
  logic                            ir_rd_wen;
  logic [ifu_pkg::rfidx_width-1:0] ir_rd_idx;
  logic [ifu_pkg::xlen-1:0]        rf_x1;
  logic [ifu_pkg::xlen-1:0]        rf_rs1;
  logic [pc_width-1:0]             pc;
  logic [ifu_pkg::rfidx_width-1:0] rf_rs1_idx;
  logic                            bpu_wait;
  logic                            prdt_taken;

  stim_row_t   table_q[$];
  logic [31:0] pc_model;
  integer      seed = 94400;

  ifu_top #(
    .pc_size  (pc_width),
    .reset_pc (start_pc)
  ) dut0 (
    .clk         (clk),
    .reset       (reset),
    .instr       (instr),
    .instr_valid (instr_valid),
    .oitf_empty  (oitf_empty),
    .ir_valid    (ir_valid),
    .ir_rd_wen   (ir_rd_wen),
    .ir_rd_idx   (ir_rd_idx),
    .rf_x1       (rf_x1),
    .rf_rs1      (rf_rs1),
    .pc          (pc),
    .rf_rs1_idx  (rf_rs1_idx),
    .bpu_wait    (bpu_wait),
    .prdt_taken  (prdt_taken)
  );

  // Hold and reset checks ride along inside the PC generator
  bind ifu_pc_gen ifu_assertions #(
    .pc_size  (pc_size),
    .reset_pc (reset_pc)
  ) assert0 (
    .clk   (clk),
    .reset (reset),
    .dec   (dec),
    .prdt  (prdt),
    .pc    (pc)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // ============================================================
  // Encoders, reference model and checks
  // ============================================================

  // Scatter the offset into the J-type fields, link register x1
  function automatic logic [31:0] encode_jal(input logic [31:0] off);
    ifu_pkg::ifu_instr_u u;
    u = '0;
    u.j_fmt.opcode    = ifu_pkg::opc_jal;
    u.j_fmt.rd        = 5'd1;
    u.j_fmt.imm_20    = off[20];
    u.j_fmt.imm_19_12 = off[19:12];
    u.j_fmt.imm_11    = off[11];
    u.j_fmt.imm_10_1  = off[10:1];
    return u;
  endfunction

  // A BNE against x2; the condition itself does not matter for static prediction
  function automatic logic [31:0] encode_branch(input logic [31:0] off, input logic [4:0] rs1);
    ifu_pkg::ifu_instr_u u;
    u = '0;
    u.b_fmt.opcode   = ifu_pkg::opc_branch;
    u.b_fmt.funct3   = 3'b001;
    u.b_fmt.rs1      = rs1;
    u.b_fmt.rs2      = 5'd2;
    u.b_fmt.imm_12   = off[12];
    u.b_fmt.imm_11   = off[11];
    u.b_fmt.imm_10_5 = off[10:5];
    u.b_fmt.imm_4_1  = off[4:1];
    return u;
  endfunction

  // Plain jump through a register, no link
  function automatic logic [31:0] encode_jalr(input logic [31:0] off, input logic [4:0] rs1);
    ifu_pkg::ifu_instr_u u;
    u = '0;
    u.i_fmt.opcode   = ifu_pkg::opc_jalr;
    u.i_fmt.rs1      = rs1;
    u.i_fmt.imm_11_0 = off[11:0];
    return u;
  endfunction

  // Next PC from the fetch rules: hold, fall through, or base plus offset with bit 0 low
  function automatic logic [31:0] ref_next_pc(input stim_row_t r, input logic [31:0] cur_pc,
                                              input logic [31:0] x1_val,
                                              input logic [31:0] rs1_val);
    logic [31:0] base;
    logic [31:0] sum;
    logic [31:0] result;
    base = cur_pc;
    if (r.kind == kind_jalr) begin
      if (r.rs1 == 5'd0) begin
        base = '0;
      end else if (r.rs1 == 5'd1) begin
        base = x1_val;
      end else begin
        base = rs1_val;
      end
    end
    sum = base + r.off;
    if (!r.instr_valid) begin
      result = cur_pc;
    end else if (r.exp_taken) begin
      result = {sum[31:1], 1'b0};
    end else begin
      result = cur_pc + 32'd4;
    end
    return result;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    if (act_val !== exp_val) begin
      $display("FAIL time=%0t signal=%s expected=%h actual=%h", $time, name, exp_val, act_val);
      $display("Verification failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s", what);
    $display("Verification failed");
    $fatal(1, "timeout");
  endtask

  // Move from one falling edge to the next, passing one rising edge
  task automatic next_cycle();
    @(posedge clk);
    @(negedge clk);
  endtask

  // The wait is combinational, so it must drop within a few ns of clearing the status
  task automatic wait_for_release();
    int count;
    count = 0;
    while (bpu_wait && count < poll_limit) begin
      #1;
      count++;
    end
    if (bpu_wait) begin
      report_timeout("bpu_wait stayed high after the JALR dependency was cleared");
    end
  endtask

  // ctrl is {instr_valid, oitf_empty, ir_valid, ir_rd_wen}, exp is {taken, wait}
  task automatic add_row(input logic [1:0] kind, input logic [31:0] off, input logic [4:0] rs1,
                         input logic [3:0] ctrl, input logic [4:0] ir_rd, input logic [1:0] exp,
                         input int hold);
    stim_row_t r;
    r.kind        = kind;
    r.off         = off;
    r.rs1         = rs1;
    r.instr_valid = ctrl[3];
    r.oitf_empty  = ctrl[2];
    r.ir_valid    = ctrl[1];
    r.ir_rd_wen   = ctrl[0];
    r.ir_rd_idx   = ir_rd;
    r.exp_taken   = exp[1];
    r.exp_wait    = exp[0];
    r.hold        = hold;
    case (kind)
      kind_jal:  r.instr = encode_jal(off);
      kind_bxx:  r.instr = encode_branch(off, rs1);
      kind_jalr: r.instr = encode_jalr(off, rs1);
      default:   r.instr = nop_instr;
    endcase
    table_q.push_back(r);
  endtask

  // ============================================================
  // Stimulus table
  // ============================================================

  task automatic build_table();
    // JAL presented without instr_valid must neither predict nor move the PC
    add_row(kind_jal,   32'h0000_0010, 5'd0,  4'b0100, 5'd0, 2'b00, 0);
    add_row(kind_other, 32'h0000_0000, 5'd0,  4'b1100, 5'd0, 2'b00, 0);
    // JAL forward and backward
    add_row(kind_jal,   32'h0000_0100, 5'd0,  4'b1100, 5'd0, 2'b10, 0);
    add_row(kind_jal,   -32'sd64,      5'd0,  4'b1100, 5'd0, 2'b10, 0);
    // BTFN: backward taken, forward falls through
    add_row(kind_bxx,   -32'sd32,      5'd3,  4'b1100, 5'd0, 2'b10, 0);
    add_row(kind_bxx,   32'h0000_0080, 5'd3,  4'b1100, 5'd0, 2'b00, 0);
    // JALR bases x0, x1 and xn with no hazard; odd offsets exercise the bit 0 clear
    add_row(kind_jalr,  32'h0000_0245, 5'd0,  4'b1100, 5'd0, 2'b10, 0);
    add_row(kind_jalr,  32'h0000_0013, 5'd1,  4'b1100, 5'd0, 2'b10, 0);
    add_row(kind_jalr,  32'h0000_07ff, 5'd1,  4'b1111, 5'd2, 2'b10, 0);
    add_row(kind_jalr,  -32'sd15,      5'd7,  4'b1110, 5'd7, 2'b10, 0);
    add_row(kind_jalr,  32'h0000_0040, 5'd12, 4'b1000, 5'd0, 2'b10, 0);
    // Hazards: IR writes x1, OITF busy with IR valid, OITF busy under an x1 base
    add_row(kind_jalr,  32'h0000_0008, 5'd1,  4'b1111, 5'd1, 2'b11, 3);
    add_row(kind_jalr,  32'h0000_0021, 5'd9,  4'b1010, 5'd4, 2'b11, 2);
    add_row(kind_jalr,  -32'sd100,     5'd1,  4'b1000, 5'd0, 2'b11, 1);
    add_row(kind_other, 32'h0000_0000, 5'd0,  4'b1100, 5'd0, 2'b00, 0);
  endtask

  // Drive on the falling edge, check the combinational outputs, then the PC after the edge
  task automatic apply_row(input stim_row_t r);
    logic [31:0] exp_pc;
    int          i;
    instr       = r.instr;
    instr_valid = r.instr_valid;
    oitf_empty  = r.oitf_empty;
    ir_valid    = r.ir_valid;
    ir_rd_wen   = r.ir_rd_wen;
    ir_rd_idx   = r.ir_rd_idx;
    rf_x1       = $random(seed);
    rf_rs1      = $random(seed);
    #5;
    check_value("prdt_taken", 32'(r.exp_taken), 32'(prdt_taken));
    check_value("bpu_wait", 32'(r.exp_wait), 32'(bpu_wait));
    if (r.kind == kind_jalr && r.instr_valid) begin
      check_value("rf_rs1_idx", 32'(r.rs1), 32'(rf_rs1_idx));
    end
    if (r.exp_wait) begin
      for (i = 0; i < r.hold; i++) begin
        next_cycle();
        check_value("pc", pc_model, pc);
        check_value("bpu_wait", 32'd1, 32'(bpu_wait));
      end
      // The producer retires, so the base register is now safe to read
      oitf_empty = 1'b1;
      ir_valid   = 1'b0;
      ir_rd_wen  = 1'b0;
      wait_for_release();
    end
    exp_pc = ref_next_pc(r, pc_model, rf_x1, rf_rs1);
    next_cycle();
    pc_model = exp_pc;
    check_value("pc", pc_model, pc);
  endtask

  // ============================================================
  // Main sequence
  // ============================================================

  initial begin
    reset       = 1'b1;
    instr       = '0;
    instr_valid = 1'b0;
    oitf_empty  = 1'b1;
    ir_valid    = 1'b0;
    ir_rd_wen   = 1'b0;
    ir_rd_idx   = '0;
    rf_x1       = '0;
    rf_rs1      = '0;
    pc_model    = start_pc;
    build_table();
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_value("pc", start_pc, pc);
    check_value("bpu_wait", 32'd0, 32'(bpu_wait));
    check_value("prdt_taken", 32'd0, 32'(prdt_taken));
    foreach (table_q[k]) begin
      apply_row(table_q[k]);
    end
    // Any mismatch has already stopped the run, so reaching here means every row matched
    $display("Verification passed");
    $finish;
  end

endmodule

/* verif/ifu_assertions.sv */
// PC hold and reset checks only; must be bound into ifu_pc_gen with the same parameters
`timescale 1ns/1ps

module ifu_assertions #(
  parameter int                       pc_size  = 32,
  parameter logic [ifu_pkg::xlen-1:0] reset_pc = 32'h0000_1000
) (
  input logic               clk,
  input logic               reset,
  input ifu_pkg::ifu_dec_t  dec,
  input ifu_pkg::ifu_prdt_t prdt,
  input logic [pc_size-1:0] pc
);

  // ============================================================
  // Wait behavior
  // ============================================================

  // A waiting JALR freezes the PC across the next rising edge
  property wait_holds_pc;
    @(posedge clk) disable iff (reset)
      prdt.wait_req |=> $stable(pc);
  endproperty

  // Only a JALR reads a register base, so nothing else can raise the wait
  property wait_only_for_jalr;
    @(posedge clk) disable iff (reset)
      prdt.wait_req |-> dec.jalr;
  endproperty

  // ============================================================
  // Reset
  // ============================================================

  // The edge after a reset cycle must show the reset PC
  property reset_loads_pc;
    @(posedge clk)
      reset |=> (pc == reset_pc[pc_size-1:0]);
  endproperty

  wait_holds_pc_a: assert property (wait_holds_pc)
    else $error("pc moved while bpu wait was high");

  wait_only_for_jalr_a: assert property (wait_only_for_jalr)
    else $error("bpu wait raised for an instruction that is not a JALR");

  reset_loads_pc_a: assert property (reset_loads_pc)
    else $error("pc does not hold the reset value after reset");

endmodule

/* hdl/ifu_top.sv */
// Fetch-side branch prediction only; instr and register status must stay stable while bpu_wait is high
`timescale 1ns/1ps

module ifu_top #(
  parameter int                       pc_size  = 32,
  parameter logic [ifu_pkg::xlen-1:0] reset_pc = 32'h0000_1000
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [ifu_pkg::xlen-1:0]        instr,
  input  logic                            instr_valid,
  input  logic                            oitf_empty,
  input  logic                            ir_valid,
  input  logic                            ir_rd_wen,
  input  logic [ifu_pkg::rfidx_width-1:0] ir_rd_idx,
  input  logic [ifu_pkg::xlen-1:0]        rf_x1,
  input  logic [ifu_pkg::xlen-1:0]        rf_rs1,
  output logic [pc_size-1:0]              pc,
  output logic [ifu_pkg::rfidx_width-1:0] rf_rs1_idx,
  output logic                            bpu_wait,
  output logic                            prdt_taken
);

  // ============================================================
  // Decode, predict, update
  // ============================================================

  // Decoded flags and immediate, shared by predictor and PC register
  ifu_pkg::ifu_dec_t  dec;

  // Prediction, wait level and adder operands
  ifu_pkg::ifu_prdt_t prdt;

  ifu_minidec minidec0 (
    .instr       (instr),
    .instr_valid (instr_valid),
    .dec         (dec)
  );

  // Current PC loops back as the base for JAL and Bxx
  ifu_bpu #(
    .pc_size (pc_size)
  ) bpu0 (
    .pc         (pc),
    .dec        (dec),
    .oitf_empty (oitf_empty),
    .ir_valid   (ir_valid),
    .ir_rd_wen  (ir_rd_wen),
    .ir_rd_idx  (ir_rd_idx),
    .rf_x1      (rf_x1),
    .rf_rs1     (rf_rs1),
    .rf_rs1_idx (rf_rs1_idx),
    .prdt       (prdt)
  );

  ifu_pc_gen #(
    .pc_size  (pc_size),
    .reset_pc (reset_pc)
  ) pc_gen0 (
    .clk   (clk),
    .reset (reset),
    .dec   (dec),
    .prdt  (prdt),
    .pc    (pc)
  );

  // Status pins are plain copies of the prediction fields
  assign bpu_wait   = prdt.wait_req;
  assign prdt_taken = prdt.taken;

endmodule

/* hdl/ifu_pc_gen.sv */
// PC advances only on a valid fetch without wait; bits above pc_size of the target sum are dropped
`timescale 1ns/1ps

module ifu_pc_gen #(
  parameter int                       pc_size  = 32,
  parameter logic [ifu_pkg::xlen-1:0] reset_pc = 32'h0000_1000
) (
  input  logic               clk,
  input  logic               reset,
  input  ifu_pkg::ifu_dec_t  dec,
  input  ifu_pkg::ifu_prdt_t prdt,
  output logic [pc_size-1:0] pc
);

  // Fixed step for a 32-bit instruction
  localparam logic [pc_size-1:0] pc_incr = pc_size'(4);

  // ============================================================
  // Next PC selection
  // ============================================================

  // Full-width result of the one target adder shared by every branch kind
  logic [ifu_pkg::xlen-1:0] tgt_sum;

  // Target with bit 0 forced low, as JALR requires
  logic [pc_size-1:0] tgt_pc;

  // Fall-through address
  logic [pc_size-1:0] seq_pc;

  // Chosen next address and its load enable
  logic [pc_size-1:0] next_pc;
  logic               pc_upd;

  assign tgt_sum = prdt.add_op1 + prdt.add_op2;

  // Clearing bit 0 is harmless for JAL and Bxx, whose offsets are already even
  assign tgt_pc = {tgt_sum[pc_size-1:1], 1'b0};

  assign seq_pc = pc + pc_incr;

  // Not-taken branches and ordinary instructions both fall through
  assign next_pc = prdt.taken ? tgt_pc : seq_pc;

  // Hold while a JALR base is unsafe or no instruction was presented
  assign pc_upd = dec.valid & ~prdt.wait_req;

  // ============================================================
  // PC register
  // ============================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_pc[pc_size-1:0];
    end else if (pc_upd) begin
      pc <= next_pc;
    end
  end

endmodule

/* hdl/ifu_bpu.sv */
// Static BTFN prediction only; JALR bases other than x0 and x1 need the register file read port
`timescale 1ns/1ps

module ifu_bpu #(
  parameter int pc_size = 32
) (
  input  logic [pc_size-1:0]              pc,
  input  ifu_pkg::ifu_dec_t               dec,
  input  logic                            oitf_empty,
  input  logic                            ir_valid,
  input  logic                            ir_rd_wen,
  input  logic [ifu_pkg::rfidx_width-1:0] ir_rd_idx,
  input  logic [ifu_pkg::xlen-1:0]        rf_x1,
  input  logic [ifu_pkg::xlen-1:0]        rf_rs1,
  output logic [ifu_pkg::rfidx_width-1:0] rf_rs1_idx,
  output ifu_pkg::ifu_prdt_t              prdt
);

  // ============================================================
  // JALR base register class
  // ============================================================

  // x0 reads as zero, x1 has a dedicated port, anything else uses read port 1
  logic rs1_x0;
  logic rs1_x1;
  logic rs1_xn;

  // The IR is about to write x1, a read-after-write hazard on the link register
  logic ir_writes_x1;

  // Hazard for each base register class, only meaningful for a JALR
  logic dep_x1;
  logic dep_xn;

  // PC widened to word width for the adder operand mux
  logic [ifu_pkg::xlen-1:0] pc_ext;

  assign rs1_x0 = (dec.rs1_idx == ifu_pkg::rfidx_width'(0));
  assign rs1_x1 = (dec.rs1_idx == ifu_pkg::rfidx_width'(1));
  assign rs1_xn = ~rs1_x0 & ~rs1_x1;

  // ============================================================
  // Dependency and wait
  // ============================================================

  assign ir_writes_x1 = ir_valid & ir_rd_wen & (ir_rd_idx == ifu_pkg::rfidx_width'(1));

  // A long op in flight may write x1, and so may the IR if its rd is x1
  assign dep_x1 = dec.jalr & rs1_x1 & (~oitf_empty | ir_writes_x1);

  // Any other base waits while both a long op and the IR are outstanding
  assign dep_xn = dec.jalr & rs1_xn & ~oitf_empty & ir_valid;

  // Wait is a level and drops as soon as the environment clears its status
  assign prdt.wait_req = dep_x1 | dep_xn;

  // ============================================================
  // Prediction
  // ============================================================

  // Jumps always go, a branch goes only when its offset points backward
  assign prdt.taken = dec.jal | dec.jalr | (dec.bxx & dec.imm[ifu_pkg::xlen-1]);

  // ============================================================
  // Adder operands
  // ============================================================

  // Upper bits above the PC width read as zero
  always_comb begin
    pc_ext = '0;
    pc_ext[pc_size-1:0] = pc;
  end

  // Base operand follows the same priority as the format decode
  always_comb begin
    if (dec.jal | dec.bxx) begin
      prdt.add_op1 = pc_ext;
    end else if (dec.jalr & rs1_x0) begin
      prdt.add_op1 = '0;
    end else if (dec.jalr & rs1_x1) begin
      prdt.add_op1 = rf_x1;
    end else begin
      prdt.add_op1 = rf_rs1;
    end
  end

  // Offset operand is the decoded immediate for every branch kind
  assign prdt.add_op2 = dec.imm;

  // Read request for the xn base goes straight to the register file
  assign rf_rs1_idx = dec.rs1_idx;

endmodule

/* hdl/ifu_minidec.sv */
// Recognizes only JAL, JALR and Bxx; funct3 is not checked, so any branch-major opcode is a Bxx
`timescale 1ns/1ps

module ifu_minidec (
  input  logic [ifu_pkg::xlen-1:0] instr,
  input  logic                     instr_valid,
  output ifu_pkg::ifu_dec_t        dec
);

  // ============================================================
  // Format views and opcode match
  // ============================================================

  // The same word is decoded three ways, picked later by opcode
  ifu_pkg::ifu_instr_u instr_u;

  // Raw opcode matches before valid gating
  logic is_jal;
  logic is_jalr;
  logic is_bxx;

  // Reassembled immediates at their natural widths
  logic [ifu_pkg::imm_j_width-1:0] imm_j;
  logic [ifu_pkg::imm_b_width-1:0] imm_b;
  logic [ifu_pkg::imm_i_width-1:0] imm_i;

  // Sign-extended immediates at full word width
  logic [ifu_pkg::xlen-1:0] imm_j_ext;
  logic [ifu_pkg::xlen-1:0] imm_b_ext;
  logic [ifu_pkg::xlen-1:0] imm_i_ext;

  assign instr_u = instr;

  // The opcode sits in the same bits in all formats, so any view would do
  assign is_jal  = (instr_u.j_fmt.opcode == ifu_pkg::opc_jal);
  assign is_jalr = (instr_u.i_fmt.opcode == ifu_pkg::opc_jalr);
  assign is_bxx  = (instr_u.b_fmt.opcode == ifu_pkg::opc_branch);

  // ============================================================
  // Immediate reassembly
  // ============================================================

  // J-type offset is a multiple of 2, bit 0 is implied zero
  assign imm_j = {instr_u.j_fmt.imm_20,
                  instr_u.j_fmt.imm_19_12,
                  instr_u.j_fmt.imm_11,
                  instr_u.j_fmt.imm_10_1,
                  1'b0};

  // B-type offset also drops bit 0, and bit 11 lives down at bit 7 of the word
  assign imm_b = {instr_u.b_fmt.imm_12,
                  instr_u.b_fmt.imm_11,
                  instr_u.b_fmt.imm_10_5,
                  instr_u.b_fmt.imm_4_1,
                  1'b0};

  // I-type offset is contiguous and keeps bit 0; the target clears it later
  assign imm_i = instr_u.i_fmt.imm_11_0;

  // Replicate each top bit so backward offsets stay negative at full width
  assign imm_j_ext = {{(ifu_pkg::xlen-ifu_pkg::imm_j_width){imm_j[ifu_pkg::imm_j_width-1]}},
                      imm_j};
  assign imm_b_ext = {{(ifu_pkg::xlen-ifu_pkg::imm_b_width){imm_b[ifu_pkg::imm_b_width-1]}},
                      imm_b};
  assign imm_i_ext = {{(ifu_pkg::xlen-ifu_pkg::imm_i_width){imm_i[ifu_pkg::imm_i_width-1]}},
                      imm_i};

  // ============================================================
  // Output bundle
  // ============================================================

  always_comb begin
    // Flags only count for a valid fetch, nothing downstream looks at instr_valid again
    dec.valid = instr_valid;
    dec.jal   = instr_valid & is_jal;
    dec.jalr  = instr_valid & is_jalr;
    dec.bxx   = instr_valid & is_bxx;

    // Pick the immediate that matches the opcode, zero for everything else
    if (is_jal) begin
      dec.imm = imm_j_ext;
    end else if (is_bxx) begin
      dec.imm = imm_b_ext;
    end else if (is_jalr) begin
      dec.imm = imm_i_ext;
    end else begin
      dec.imm = '0;
    end

    // rs1 shares its bit position in the B and I views, so the I view serves both
    dec.rs1_idx = instr_u.i_fmt.rs1;
  end

endmodule

/* hdl/ifu_pkg.sv */
// Shared RV32 fetch types; assumes 32-bit uncompressed instructions and xlen of 32 only

// ============================================================
// Widths and opcodes
// ============================================================
package ifu_pkg;

  // Data word width, also the width of one instruction word
  localparam int xlen = 32;

  // Register index width for the 32 integer registers
  localparam int rfidx_width = 5;

  // Major opcode width in the low bits of every instruction
  localparam int opc_width = 7;

  // Sign-extension source widths of the three immediate formats
  localparam int imm_j_width = 21;
  localparam int imm_b_width = 13;
  localparam int imm_i_width = 12;

  // The only opcodes the mini-decoder has to recognize
  localparam logic [opc_width-1:0] opc_jal    = 7'b1101111;
  localparam logic [opc_width-1:0] opc_jalr   = 7'b1100111;
  localparam logic [opc_width-1:0] opc_branch = 7'b1100011;

  // ============================================================
  // Instruction formats
  // ============================================================

  // Conditional branch layout, immediate bits scattered around rs1 and rs2
  typedef struct packed {
    logic                   imm_12;
    logic [5:0]             imm_10_5;
    logic [rfidx_width-1:0] rs2;
    logic [rfidx_width-1:0] rs1;
    logic [2:0]             funct3;
    logic [3:0]             imm_4_1;
    logic                   imm_11;
    logic [opc_width-1:0]   opcode;
  } ifu_b_fmt_t;

  // JAL layout; the rs1 position is reused by the upper immediate bits
  typedef struct packed {
    logic                   imm_20;
    logic [9:0]             imm_10_1;
    logic                   imm_11;
    logic [7:0]             imm_19_12;
    logic [rfidx_width-1:0] rd;
    logic [opc_width-1:0]   opcode;
  } ifu_j_fmt_t;

  // JALR layout, a plain 12-bit immediate above rs1
  typedef struct packed {
    logic [11:0]            imm_11_0;
    logic [rfidx_width-1:0] rs1;
    logic [2:0]             funct3;
    logic [rfidx_width-1:0] rd;
    logic [opc_width-1:0]   opcode;
  } ifu_i_fmt_t;

  // One fetched word seen through each of the three formats
  typedef union packed {
    ifu_b_fmt_t b_fmt;
    ifu_j_fmt_t j_fmt;
    ifu_i_fmt_t i_fmt;
  } ifu_instr_u;

  // ============================================================
  // Decode and prediction bundles
  // ============================================================

  // Decoder result, flags already qualified by the instruction valid level
  typedef struct packed {
    logic                   valid;
    logic                   jal;
    logic                   jalr;
    logic                   bxx;
    logic [xlen-1:0]        imm;
    logic [rfidx_width-1:0] rs1_idx;
  } ifu_dec_t;

  // Predictor result; wait_req freezes the PC until a JALR base is safe to read
  typedef struct packed {
    logic            taken;
    logic            wait_req;
    logic [xlen-1:0] add_op1;
    logic [xlen-1:0] add_op2;
  } ifu_prdt_t;

endpackage
